// File: rtl/decodePkg.sv
`default_nettype none

package decodePkg;

    ////////////////////
    // widths and vectors
    ////////////////////
    localparam int INSTR_W  = 32;
    localparam int ADDR_W   = 32;
    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;

    localparam logic [ADDR_W-1:0] RESET_PC = 32'hBFC0_0000;  // boot rom, kseg1

    // regimm branches are selected by the rt field
    localparam logic [REG_W-1:0] RT_BLTZ   = 5'b00000;
    localparam logic [REG_W-1:0] RT_BGEZ   = 5'b00001;
    localparam logic [REG_W-1:0] RT_BLTZAL = 5'b10000;
    localparam logic [REG_W-1:0] RT_BGEZAL = 5'b10001;

    localparam logic [REG_W-1:0]    RS_MF      = 5'b00000;  // cop0 move from
    localparam logic [REG_W-1:0]    RS_MT      = 5'b00100;  // cop0 move to
    localparam logic [REG_W-1:0]    RS_CO      = 5'b10000;  // cop0 function group
    localparam logic [OPCODE_W-1:0] ERET_FUNCT = 6'b011000;

    ////////////////////
    // encodings
    ////////////////////
    typedef enum logic [OPCODE_W-1:0] {
        OPC_SPECIAL = 6'b000000, OPC_REGIMM = 6'b000001,
        OPC_J       = 6'b000010, OPC_JAL    = 6'b000011,
        OPC_BEQ     = 6'b000100, OPC_BNE    = 6'b000101,
        OPC_BLEZ    = 6'b000110, OPC_BGTZ   = 6'b000111,
        OPC_ADDI    = 6'b001000, OPC_ADDIU  = 6'b001001,
        OPC_SLTI    = 6'b001010, OPC_SLTIU  = 6'b001011,
        OPC_ANDI    = 6'b001100, OPC_ORI    = 6'b001101,
        OPC_XORI    = 6'b001110, OPC_LUI    = 6'b001111,
        OPC_COP0    = 6'b010000,
        OPC_LB      = 6'b100000, OPC_LH     = 6'b100001,
        OPC_LW      = 6'b100011, OPC_LBU    = 6'b100100,
        OPC_LHU     = 6'b100101, OPC_SB     = 6'b101000,
        OPC_SH      = 6'b101001, OPC_SW     = 6'b101011
    } Opcode;

    typedef enum logic [OPCODE_W-1:0] {
        FN_SLL  = 6'b000000, FN_SRL   = 6'b000010, FN_SRA     = 6'b000011,
        FN_SLLV = 6'b000100, FN_SRLV  = 6'b000110, FN_SRAV    = 6'b000111,
        FN_JR   = 6'b001000, FN_JALR  = 6'b001001, FN_SYSCALL = 6'b001100,
        FN_BREAK = 6'b001101,
        FN_MFHI = 6'b010000, FN_MTHI  = 6'b010001, FN_MFLO    = 6'b010010,
        FN_MTLO = 6'b010011, FN_MULT  = 6'b011000, FN_MULTU   = 6'b011001,
        FN_DIV  = 6'b011010, FN_DIVU  = 6'b011011,
        FN_ADD  = 6'b100000, FN_ADDU  = 6'b100001, FN_SUB     = 6'b100010,
        FN_SUBU = 6'b100011, FN_AND   = 6'b100100, FN_OR      = 6'b100101,
        FN_XOR  = 6'b100110, FN_NOR   = 6'b100111, FN_SLT     = 6'b101010,
        FN_SLTU = 6'b101011
    } Funct;

    typedef enum logic [5:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_JR, OP_JALR, OP_SYSCALL, OP_BREAK,
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW,
        OP_MFC0, OP_MTC0, OP_ERET,
        OP_INVALID
    } InstrType;

    typedef enum logic [4:0] {
        ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR,
        LUI, SLL, SRL, SRA, MULT, MULTU, DIV, DIVU, NOP
    } AluOp;

    typedef enum logic [2:0] {NONE, SYSCALL, BREAK, ERET, RESERVED} ExceptType;

    ////////////////////
    // control fields
    ////////////////////
    typedef enum logic [2:0] {LD_NONE, LD_B, LD_BU, LD_H, LD_HU, LD_W} LoadType;
    typedef enum logic [1:0] {ST_NONE, ST_B, ST_H, ST_W} StoreType;
    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ, BR_BLTZ, BR_BGEZ, BR_JR
    } BranchType;
    typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_HI, WB_LO, WB_CP0, WB_PC8} WbSel;
    typedef enum logic [1:0] {DST_RD, DST_RT, DST_R31} DstSel;
    typedef enum logic [1:0] {EXT_SIGN, EXT_ZERO, EXT_UPPER} ExtOp;
    typedef enum logic {SRCA_REG, SRCA_SHAMT} AluSrcA;
    typedef enum logic {SRCB_REG, SRCB_IMM} AluSrcB;

    typedef struct packed {
        logic [ADDR_W-1:0]  pc;
        logic [INSTR_W-1:0] instr;
    } FetchPkt;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        InstrType          instrType;
        AluOp              aluOp;
        LoadType           loadType;
        StoreType          storeType;
        BranchType         branchType;
        WbSel              wbSel;
        DstSel             dstSel;
        ExtOp              extOp;
        AluSrcA            aluSrcA;
        AluSrcB            aluSrcB;
        logic              regWrite;
        logic              isImmeJump;   // j/jal target from instr_index
        ExceptType         exceptType;
    } CtrlBundle;

endpackage

`default_nettype wire

// File: rtl/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import decodePkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               imemValid,
    input  logic [INSTR_W-1:0] imemData,
    input  logic               redirectValid,
    input  logic [ADDR_W-1:0]  redirectPc,
    output logic               fetchValid,
    output FetchPkt            fetchPkt
);

    logic [ADDR_W-1:0] pc;     // pc of the next accepted word
    logic              accept;

    assign accept = imemValid && !redirectValid;  // redirect wins

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc         <= RESET_PC;
            fetchValid <= 1'b0;
        end else if (redirectValid) begin
            pc         <= redirectPc;
            fetchValid <= 1'b0;    // drop the word in this stage
        end else begin
            fetchValid <= imemValid;
            if (imemValid) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetchPkt.pc    <= pc;
            fetchPkt.instr <= imemData;
        end
    end

    aRedirectAligned: assert property (@(posedge clk) disable iff (!rstN)
        redirectValid |-> redirectPc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/ifIdReg.sv
`timescale 1ns/1ps
`default_nettype none

module ifIdReg import decodePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    fetchValid,
    input  FetchPkt fetchPkt,
    input  logic    redirectValid,
    output logic    idValid,
    output FetchPkt idPkt
);

    // flush only clears the flag, the payload is don't care then
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idValid <= 1'b0;
        end else begin
            idValid <= fetchValid && !redirectValid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            idPkt <= fetchPkt;  // held between strobes
        end
    end

endmodule

`default_nettype wire

// File: rtl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import decodePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      idValid,
    input  FetchPkt   idPkt,
    output logic      ctrlValid,
    output CtrlBundle ctrl
);

    logic [OPCODE_W-1:0] opcode;
    logic [OPCODE_W-1:0] funct;
    logic [REG_W-1:0]    rs;
    logic [REG_W-1:0]    rt;
    logic [REG_W-1:0]    shamt;
    InstrType            instrType;
    CtrlBundle           ctrlNext;
    logic                isRAlu;
    logic                isIAlu;
    logic                isLoad;
    logic                isLink;

    assign opcode = idPkt.instr[31:26];
    assign rs     = idPkt.instr[25:21];
    assign rt     = idPkt.instr[20:16];
    assign shamt  = idPkt.instr[10:6];
    assign funct  = idPkt.instr[5:0];

    ////////////////////
    // step 1, word to type
    ////////////////////
    always_comb begin
        instrType = OP_INVALID;  // anything not matched below
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADD:     instrType = OP_ADD;
                    FN_ADDU:    instrType = OP_ADDU;
                    FN_SUB:     instrType = OP_SUB;
                    FN_SUBU:    instrType = OP_SUBU;
                    FN_SLT:     instrType = OP_SLT;
                    FN_SLTU:    instrType = OP_SLTU;
                    FN_AND:     instrType = OP_AND;
                    FN_OR:      instrType = OP_OR;
                    FN_XOR:     instrType = OP_XOR;
                    FN_NOR:     instrType = OP_NOR;
                    FN_SLL:     instrType = (rs == '0) ? OP_SLL : OP_INVALID;
                    FN_SRL:     instrType = (rs == '0) ? OP_SRL : OP_INVALID;
                    FN_SRA:     instrType = (rs == '0) ? OP_SRA : OP_INVALID;
                    FN_SLLV:    instrType = (shamt == '0) ? OP_SLLV : OP_INVALID;
                    FN_SRLV:    instrType = (shamt == '0) ? OP_SRLV : OP_INVALID;
                    FN_SRAV:    instrType = (shamt == '0) ? OP_SRAV : OP_INVALID;
                    FN_MULT:    instrType = OP_MULT;
                    FN_MULTU:   instrType = OP_MULTU;
                    FN_DIV:     instrType = OP_DIV;
                    FN_DIVU:    instrType = OP_DIVU;
                    FN_MFHI:    instrType = OP_MFHI;
                    FN_MFLO:    instrType = OP_MFLO;
                    FN_MTHI:    instrType = OP_MTHI;
                    FN_MTLO:    instrType = OP_MTLO;
                    FN_JR:      instrType = OP_JR;
                    FN_JALR:    instrType = OP_JALR;
                    FN_SYSCALL: instrType = OP_SYSCALL;
                    FN_BREAK:   instrType = OP_BREAK;
                    default:    instrType = OP_INVALID;
                endcase
            end
            OPC_REGIMM: begin
                case (rt)
                    RT_BLTZ:   instrType = OP_BLTZ;
                    RT_BGEZ:   instrType = OP_BGEZ;
                    RT_BLTZAL: instrType = OP_BLTZAL;
                    RT_BGEZAL: instrType = OP_BGEZAL;
                    default:   instrType = OP_INVALID;
                endcase
            end
            OPC_J:     instrType = OP_J;
            OPC_JAL:   instrType = OP_JAL;
            OPC_BEQ:   instrType = OP_BEQ;
            OPC_BNE:   instrType = OP_BNE;
            OPC_BLEZ:  instrType = OP_BLEZ;
            OPC_BGTZ:  instrType = OP_BGTZ;
            OPC_ADDI:  instrType = OP_ADDI;
            OPC_ADDIU: instrType = OP_ADDIU;
            OPC_SLTI:  instrType = OP_SLTI;
            OPC_SLTIU: instrType = OP_SLTIU;
            OPC_ANDI:  instrType = OP_ANDI;
            OPC_ORI:   instrType = OP_ORI;
            OPC_XORI:  instrType = OP_XORI;
            OPC_LUI:   instrType = OP_LUI;
            OPC_LB:    instrType = OP_LB;
            OPC_LBU:   instrType = OP_LBU;
            OPC_LH:    instrType = OP_LH;
            OPC_LHU:   instrType = OP_LHU;
            OPC_LW:    instrType = OP_LW;
            OPC_SB:    instrType = OP_SB;
            OPC_SH:    instrType = OP_SH;
            OPC_SW:    instrType = OP_SW;
            OPC_COP0: begin
                if (rs == RS_MF) begin
                    instrType = OP_MFC0;
                end else if (rs == RS_MT) begin
                    instrType = OP_MTC0;
                end else if (rs == RS_CO && funct == ERET_FUNCT) begin
                    instrType = OP_ERET;
                end
            end
            default:   instrType = OP_INVALID;  // lwl/lwr/swl/swr/cache land here
        endcase
    end

    ////////////////////
    // step 2, type to bundle
    ////////////////////
    assign isRAlu = instrType inside {OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
                                      OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL,
                                      OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV};
    assign isIAlu = instrType inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                      OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    assign isLoad = instrType inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign isLink = instrType inside {OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL};  // write pc+8

    always_comb begin
        ctrlNext.pc         = idPkt.pc;
        ctrlNext.instrType  = instrType;
        ctrlNext.regWrite   = isRAlu || isIAlu || isLoad || isLink
                              || instrType inside {OP_MFHI, OP_MFLO, OP_MFC0};
        ctrlNext.isImmeJump = instrType inside {OP_J, OP_JAL};
        ctrlNext.aluSrcA    = (instrType inside {OP_SLL, OP_SRL, OP_SRA}) ? SRCA_SHAMT : SRCA_REG;
        ctrlNext.aluSrcB    = (isIAlu || isLoad || instrType inside {OP_SB, OP_SH, OP_SW})
                              ? SRCB_IMM : SRCB_REG;

        if (isIAlu || isLoad || instrType == OP_MFC0) begin
            ctrlNext.dstSel = DST_RT;
        end else if (instrType inside {OP_JAL, OP_BLTZAL, OP_BGEZAL}) begin
            ctrlNext.dstSel = DST_R31;
        end else begin
            ctrlNext.dstSel = DST_RD;
        end

        case (instrType)
            OP_ANDI, OP_ORI, OP_XORI: ctrlNext.extOp = EXT_ZERO;
            OP_LUI:                   ctrlNext.extOp = EXT_UPPER;
            default:                  ctrlNext.extOp = EXT_SIGN;
        endcase

        case (instrType)
            OP_ADD, OP_ADDI:   ctrlNext.aluOp = ADD;
            OP_ADDU, OP_ADDIU: ctrlNext.aluOp = ADDU;
            OP_SUB:            ctrlNext.aluOp = SUB;
            OP_SUBU:           ctrlNext.aluOp = SUBU;
            OP_SLT, OP_SLTI:   ctrlNext.aluOp = SLT;
            OP_SLTU, OP_SLTIU: ctrlNext.aluOp = SLTU;
            OP_AND, OP_ANDI:   ctrlNext.aluOp = AND;
            OP_OR, OP_ORI:     ctrlNext.aluOp = OR;
            OP_XOR, OP_XORI:   ctrlNext.aluOp = XOR;
            OP_NOR:            ctrlNext.aluOp = NOR;
            OP_LUI:            ctrlNext.aluOp = LUI;
            OP_SLL, OP_SLLV:   ctrlNext.aluOp = SLL;
            OP_SRL, OP_SRLV:   ctrlNext.aluOp = SRL;
            OP_SRA, OP_SRAV:   ctrlNext.aluOp = SRA;
            OP_MULT:           ctrlNext.aluOp = MULT;
            OP_MULTU:          ctrlNext.aluOp = MULTU;
            OP_DIV:            ctrlNext.aluOp = DIV;
            OP_DIVU:           ctrlNext.aluOp = DIVU;
            default:           ctrlNext.aluOp = NOP;
        endcase

        case (instrType)
            OP_LB:   ctrlNext.loadType = LD_B;
            OP_LBU:  ctrlNext.loadType = LD_BU;
            OP_LH:   ctrlNext.loadType = LD_H;
            OP_LHU:  ctrlNext.loadType = LD_HU;
            OP_LW:   ctrlNext.loadType = LD_W;
            default: ctrlNext.loadType = LD_NONE;
        endcase

        case (instrType)
            OP_SB:   ctrlNext.storeType = ST_B;
            OP_SH:   ctrlNext.storeType = ST_H;
            OP_SW:   ctrlNext.storeType = ST_W;
            default: ctrlNext.storeType = ST_NONE;
        endcase

        case (instrType)
            OP_BEQ:              ctrlNext.branchType = BR_BEQ;
            OP_BNE:              ctrlNext.branchType = BR_BNE;
            OP_BLEZ:             ctrlNext.branchType = BR_BLEZ;
            OP_BGTZ:             ctrlNext.branchType = BR_BGTZ;
            OP_BLTZ, OP_BLTZAL:  ctrlNext.branchType = BR_BLTZ;
            OP_BGEZ, OP_BGEZAL:  ctrlNext.branchType = BR_BGEZ;
            OP_JR, OP_JALR:      ctrlNext.branchType = BR_JR;  // register target
            default:             ctrlNext.branchType = BR_NONE;
        endcase

        if (isLoad) begin
            ctrlNext.wbSel = WB_MEM;
        end else if (isLink) begin
            ctrlNext.wbSel = WB_PC8;
        end else if (instrType == OP_MFHI) begin
            ctrlNext.wbSel = WB_HI;
        end else if (instrType == OP_MFLO) begin
            ctrlNext.wbSel = WB_LO;
        end else if (instrType == OP_MFC0) begin
            ctrlNext.wbSel = WB_CP0;
        end else begin
            ctrlNext.wbSel = WB_ALU;
        end

        case (instrType)
            OP_SYSCALL: ctrlNext.exceptType = SYSCALL;
            OP_BREAK:   ctrlNext.exceptType = BREAK;
            OP_ERET:    ctrlNext.exceptType = ERET;
            OP_INVALID: ctrlNext.exceptType = RESERVED;  // reserved instruction trap
            default:    ctrlNext.exceptType = NONE;
        endcase
    end

    ////////////////////
    // id/ex register
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
        end else begin
            ctrlValid <= idValid;
        end
    end

    always_ff @(posedge clk) begin
        if (idValid) begin
            ctrl <= ctrlNext;
        end
    end

    aReservedQuiet: assert property (@(posedge clk) disable iff (!rstN)
        ctrlValid && ctrl.exceptType == RESERVED
            |-> !ctrl.regWrite && ctrl.loadType == LD_NONE && ctrl.storeType == ST_NONE);

endmodule

`default_nettype wire

// File: rtl/decodeTop.sv
`timescale 1ns/1ps
`default_nettype none

module decodeTop import decodePkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               imemValid,
    input  logic [INSTR_W-1:0] imemData,
    input  logic               redirectValid,
    input  logic [ADDR_W-1:0]  redirectPc,
    output logic               ctrlValid,
    output CtrlBundle          ctrl
);

    logic    fetchValid;
    FetchPkt fetchPkt;
    logic    idValid;
    FetchPkt idPkt;

    fetchUnit uFetch (
        .clk           (clk),
        .rstN          (rstN),
        .imemValid     (imemValid),
        .imemData      (imemData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .fetchValid    (fetchValid),
        .fetchPkt      (fetchPkt)
    );

    ifIdReg uIfId (
        .clk           (clk),
        .rstN          (rstN),
        .fetchValid    (fetchValid),
        .fetchPkt      (fetchPkt),
        .redirectValid (redirectValid),  // flush
        .idValid       (idValid),
        .idPkt         (idPkt)
    );

    instrDecoder uDecode (
        .clk       (clk),
        .rstN      (rstN),
        .idValid   (idValid),
        .idPkt     (idPkt),
        .ctrlValid (ctrlValid),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// File: bench/refModel.sv
`timescale 1ns/1ps
`default_nettype none

module refModel import decodePkg::*; (
    input  logic [INSTR_W-1:0] instr,
    input  logic [ADDR_W-1:0]  pc,
    output CtrlBundle          expCtrl
);

    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] sa;
    InstrType   t;

    assign op = instr[31:26];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign sa = instr[10:6];
    assign fn = instr[5:0];

    ////////////////////
    // classification
    ////////////////////
    always_comb begin
        t = OP_INVALID;
        if (op == 6'd0) begin
            case (fn)
                6'd0:  t = (rs == 5'd0) ? OP_SLL : OP_INVALID;  // rs must be zero
                6'd2:  t = (rs == 5'd0) ? OP_SRL : OP_INVALID;
                6'd3:  t = (rs == 5'd0) ? OP_SRA : OP_INVALID;
                6'd4:  t = (sa == 5'd0) ? OP_SLLV : OP_INVALID;  // shamt must be zero
                6'd6:  t = (sa == 5'd0) ? OP_SRLV : OP_INVALID;
                6'd7:  t = (sa == 5'd0) ? OP_SRAV : OP_INVALID;
                6'd8:  t = OP_JR;
                6'd9:  t = OP_JALR;
                6'd12: t = OP_SYSCALL;
                6'd13: t = OP_BREAK;
                6'd16: t = OP_MFHI;
                6'd17: t = OP_MTHI;
                6'd18: t = OP_MFLO;
                6'd19: t = OP_MTLO;
                6'd24: t = OP_MULT;
                6'd25: t = OP_MULTU;
                6'd26: t = OP_DIV;
                6'd27: t = OP_DIVU;
                6'd32: t = OP_ADD;
                6'd33: t = OP_ADDU;
                6'd34: t = OP_SUB;
                6'd35: t = OP_SUBU;
                6'd36: t = OP_AND;
                6'd37: t = OP_OR;
                6'd38: t = OP_XOR;
                6'd39: t = OP_NOR;
                6'd42: t = OP_SLT;
                6'd43: t = OP_SLTU;
                default: t = OP_INVALID;
            endcase
        end else if (op == 6'd1) begin
            if (rt == 5'd0) t = OP_BLTZ;
            else if (rt == 5'd1) t = OP_BGEZ;
            else if (rt == 5'd16) t = OP_BLTZAL;
            else if (rt == 5'd17) t = OP_BGEZAL;
        end else if (op == 6'd16) begin
            if (rs == 5'd0) t = OP_MFC0;
            else if (rs == 5'd4) t = OP_MTC0;
            else if (rs == 5'd16 && fn == 6'd24) t = OP_ERET;
        end else begin
            case (op)
                6'd2:  t = OP_J;
                6'd3:  t = OP_JAL;
                6'd4:  t = OP_BEQ;
                6'd5:  t = OP_BNE;
                6'd6:  t = OP_BLEZ;
                6'd7:  t = OP_BGTZ;
                6'd8:  t = OP_ADDI;
                6'd9:  t = OP_ADDIU;
                6'd10: t = OP_SLTI;
                6'd11: t = OP_SLTIU;
                6'd12: t = OP_ANDI;
                6'd13: t = OP_ORI;
                6'd14: t = OP_XORI;
                6'd15: t = OP_LUI;
                6'd32: t = OP_LB;
                6'd33: t = OP_LH;
                6'd35: t = OP_LW;
                6'd36: t = OP_LBU;
                6'd37: t = OP_LHU;
                6'd40: t = OP_SB;
                6'd41: t = OP_SH;
                6'd43: t = OP_SW;
                default: t = OP_INVALID;  // lwl, swr, cache and friends
            endcase
        end
    end

    ////////////////////
    // rule table
    ////////////////////
    always_comb begin
        expCtrl           = '0;  // all enums at their first value
        expCtrl.pc        = pc;
        expCtrl.instrType = t;
        expCtrl.aluOp     = NOP;
        case (t)
            OP_ADD, OP_ADDI:   expCtrl.aluOp = ADD;
            OP_ADDU, OP_ADDIU: expCtrl.aluOp = ADDU;
            OP_SUB:            expCtrl.aluOp = SUB;
            OP_SUBU:           expCtrl.aluOp = SUBU;
            OP_SLT, OP_SLTI:   expCtrl.aluOp = SLT;
            OP_SLTU, OP_SLTIU: expCtrl.aluOp = SLTU;
            OP_AND, OP_ANDI:   expCtrl.aluOp = AND;
            OP_OR, OP_ORI:     expCtrl.aluOp = OR;
            OP_XOR, OP_XORI:   expCtrl.aluOp = XOR;
            OP_NOR:            expCtrl.aluOp = NOR;
            OP_LUI:            expCtrl.aluOp = LUI;
            OP_SLL, OP_SLLV:   expCtrl.aluOp = SLL;
            OP_SRL, OP_SRLV:   expCtrl.aluOp = SRL;
            OP_SRA, OP_SRAV:   expCtrl.aluOp = SRA;
            OP_MULT:           expCtrl.aluOp = MULT;
            OP_MULTU:          expCtrl.aluOp = MULTU;
            OP_DIV:            expCtrl.aluOp = DIV;
            OP_DIVU:           expCtrl.aluOp = DIVU;
            default:           expCtrl.aluOp = NOP;
        endcase
        case (t)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_AND, OP_OR,
            OP_XOR, OP_NOR, OP_SLLV, OP_SRLV, OP_SRAV, OP_JALR:
                expCtrl.regWrite = 1'b1;
            OP_SLL, OP_SRL, OP_SRA: begin
                expCtrl.regWrite = 1'b1;
                expCtrl.aluSrcA  = SRCA_SHAMT;
            end
            OP_MFHI: begin
                expCtrl.regWrite = 1'b1;
                expCtrl.wbSel    = WB_HI;
            end
            OP_MFLO: begin
                expCtrl.regWrite = 1'b1;
                expCtrl.wbSel    = WB_LO;
            end
            OP_MFC0: begin
                expCtrl.regWrite = 1'b1;
                expCtrl.wbSel    = WB_CP0;
                expCtrl.dstSel   = DST_RT;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                expCtrl.regWrite = 1'b1;
                expCtrl.dstSel   = DST_RT;
                expCtrl.aluSrcB  = SRCB_IMM;
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                expCtrl.regWrite = 1'b1;
                expCtrl.dstSel   = DST_RT;
                expCtrl.aluSrcB  = SRCB_IMM;
                expCtrl.wbSel    = WB_MEM;
            end
            OP_SB, OP_SH, OP_SW: expCtrl.aluSrcB = SRCB_IMM;
            OP_JAL, OP_BLTZAL, OP_BGEZAL: begin
                expCtrl.regWrite = 1'b1;
                expCtrl.dstSel   = DST_R31;
            end
            default: expCtrl.regWrite = 1'b0;
        endcase
        if (t inside {OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL}) expCtrl.wbSel = WB_PC8;
        if (t inside {OP_ANDI, OP_ORI, OP_XORI}) expCtrl.extOp = EXT_ZERO;
        if (t == OP_LUI) expCtrl.extOp = EXT_UPPER;
        expCtrl.isImmeJump = (t == OP_J) || (t == OP_JAL);
        case (t)
            OP_LB:  expCtrl.loadType = LD_B;
            OP_LBU: expCtrl.loadType = LD_BU;
            OP_LH:  expCtrl.loadType = LD_H;
            OP_LHU: expCtrl.loadType = LD_HU;
            OP_LW:  expCtrl.loadType = LD_W;
            OP_SB:  expCtrl.storeType = ST_B;
            OP_SH:  expCtrl.storeType = ST_H;
            OP_SW:  expCtrl.storeType = ST_W;
            OP_BEQ:  expCtrl.branchType = BR_BEQ;
            OP_BNE:  expCtrl.branchType = BR_BNE;
            OP_BLEZ: expCtrl.branchType = BR_BLEZ;
            OP_BGTZ: expCtrl.branchType = BR_BGTZ;
            OP_BLTZ, OP_BLTZAL: expCtrl.branchType = BR_BLTZ;
            OP_BGEZ, OP_BGEZAL: expCtrl.branchType = BR_BGEZ;
            OP_JR, OP_JALR:     expCtrl.branchType = BR_JR;
            OP_SYSCALL: expCtrl.exceptType = SYSCALL;
            OP_BREAK:   expCtrl.exceptType = BREAK;
            OP_ERET:    expCtrl.exceptType = ERET;
            OP_INVALID: expCtrl.exceptType = RESERVED;
            default:    expCtrl.exceptType = NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: bench/tbDecode.sv
`timescale 1ns/1ps
`default_nettype none

module tbDecode import decodePkg::*; ();

    localparam int NUM_CYCLES = 800;
    localparam int CLK_NS     = 40;

    localparam logic [5:0] R_FUNCTS [28] = '{
        6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd8, 6'd9, 6'd12, 6'd13,
        6'd16, 6'd17, 6'd18, 6'd19, 6'd24, 6'd25, 6'd26, 6'd27, 6'd32, 6'd33,
        6'd34, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43
    };
    localparam logic [5:0] I_OPS [22] = '{
        6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7, 6'd8, 6'd9, 6'd10, 6'd11, 6'd12,
        6'd13, 6'd14, 6'd15, 6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd40, 6'd41, 6'd43
    };

    logic               clk;
    logic               rstN;
    logic               imemValid;
    logic [INSTR_W-1:0] imemData;
    logic               redirectValid;
    logic [ADDR_W-1:0]  redirectPc;
    logic               ctrlValid;
    CtrlBundle          ctrl;

    logic [INSTR_W-1:0] refInstr;
    logic [ADDR_W-1:0]  refPc;
    CtrlBundle          refOut;

    CtrlBundle   expQ [$];
    int          issueQ [$];
    CtrlBundle   expCur;
    int          issueCur;
    logic        haveExp;
    logic [31:0] lcgState;
    int          cyc;
    int          strobes;

    decodeTop uut (
        .clk           (clk),
        .rstN          (rstN),
        .imemValid     (imemValid),
        .imemData      (imemData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .ctrlValid     (ctrlValid),
        .ctrl          (ctrl)
    );

    refModel uRef (
        .instr   (refInstr),
        .pc      (refPc),
        .expCtrl (refOut)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {lcgState[15:0], lcgState[31:16]};  // low lcg bits cycle fast
    endfunction

    ////////////////////
    // instruction words by class
    ////////////////////
    function automatic logic [31:0] makeWord();
        logic [31:0] w;
        logic [31:0] r;
        logic [31:0] cls;
        w   = nextRand();
        r   = nextRand();
        cls = nextRand() % 32'd8;
        case (cls)
            32'd0, 32'd5, 32'd6: begin
                w[31:26] = 6'd0;
                w[5:0]   = R_FUNCTS[r[20:16] % 5'd28];
                if (r[0]) w[25:21] = 5'd0;   // mostly legal shifts
                if (r[1]) w[10:6]  = 5'd0;
            end
            32'd1: begin
                w[31:26] = 6'd1;
                if (r[3:2] != 2'b11) w[20:16] = {r[1], 3'b000, r[0]};
            end
            32'd2, 32'd7: w[31:26] = I_OPS[r[20:16] % 5'd22];
            32'd3: begin
                w[31:26] = 6'd16;
                case (r[1:0])
                    2'd0: w[25:21] = 5'd0;
                    2'd1: w[25:21] = 5'd4;
                    2'd2: begin
                        w[25:21] = 5'd16;
                        w[5:0]   = 6'd24;  // eret
                    end
                    default: w[25:21] = r[12:8];
                endcase
            end
            default: w = w ^ r;  // fully random word
        endcase
        return w;
    endfunction

    task automatic reportFail(input string name, input CtrlBundle exp, input CtrlBundle act);
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
        $display("Test failed");
        $fatal(1);
    endtask

    // expected bundle for the cycle in which ctrlValid is high
    always @(negedge clk) begin
        if (rstN && ctrlValid) begin
            if (expQ.size() > 0) begin
                expCur   = expQ.pop_front();
                issueCur = issueQ.pop_front();
                haveExp  = 1'b1;
            end else begin
                haveExp = 1'b0;
            end
        end
    end

    aOutputExpected: assert property (@(posedge clk) disable iff (!rstN)
        ctrlValid |-> haveExp)
        else begin
            $display("an output appeared with no accepted instruction pending");
            $display("Test failed");
            $fatal(1);
        end

    aBundleMatch: assert property (@(posedge clk) disable iff (!rstN)
        ctrlValid |-> ctrl == expCur)
        else reportFail("bundle", $sampled(expCur), $sampled(ctrl));

    aLatency: assert property (@(posedge clk) disable iff (!rstN)
        ctrlValid |-> cyc == issueCur + 3)
        else begin
            $display("[FAIL] latency expected %0d actual %0d", 3, $sampled(cyc) - issueCur);
            $display("Test failed");
            $fatal(1);
        end

    aResetQuiet: assert property (@(posedge clk) disable iff (!rstN)
        (strobes == 0) |-> !ctrlValid)
        else begin
            $display("ctrlValid went high before any instruction strobe");
            $display("Test failed");
            $fatal(1);
        end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        logic [31:0] word;
        logic [31:0] r;
        logic [31:0] pcModel;
        clk           = 1'b0;
        rstN          = 1'b0;
        imemValid     = 1'b0;
        imemData      = '0;
        redirectValid = 1'b0;
        redirectPc    = '0;
        refInstr      = '0;
        refPc         = '0;
        expCur        = '0;
        issueCur      = 0;
        haveExp       = 1'b0;
        lcgState      = 32'd62584;
        cyc           = 0;
        strobes       = 0;
        pcModel       = RESET_PC;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge clk);
            r        = nextRand();
            word     = makeWord();
            refInstr = word;
            refPc    = pcModel;
            #1;
            @(posedge clk);
            cyc           = cyc + 1;
            imemValid     <= 1'b0;
            redirectValid <= 1'b0;
            if (i < 3) begin
                // idle after reset
            end else if (r[31:27] == 5'd0) begin
                pcModel        = nextRand() & 32'hFFFF_FFFC;
                redirectValid <= 1'b1;
                redirectPc    <= pcModel;
                imemValid     <= r[0];   // discarded
                imemData      <= word;
                if (issueQ.size() > 0 && issueQ[$] == cyc - 1) begin
                    void'(expQ.pop_back());
                    void'(issueQ.pop_back());
                end
            end else if (r[26:24] < 3'd5) begin
                imemValid <= 1'b1;
                imemData  <= word;
                expQ.push_back(refOut);
                issueQ.push_back(cyc);
                strobes = strobes + 1;
                pcModel = pcModel + 32'd4;
            end
        end
        @(posedge clk);
        cyc           = cyc + 1;
        imemValid     <= 1'b0;
        redirectValid <= 1'b0;
        repeat (10) begin
            @(posedge clk);
            cyc = cyc + 1;
        end
        if (expQ.size() == 0 && strobes > 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d expected outputs never appeared", expQ.size());
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        #((NUM_CYCLES + 4 + 20) * CLK_NS);
        $display("timeout, the run did not finish in time");
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: list.f
rtl/decodePkg.sv
rtl/fetchUnit.sv
rtl/ifIdReg.sv
rtl/instrDecoder.sv
rtl/decodeTop.sv
bench/refModel.sv
bench/tbDecode.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbDecode -f list.f -o simDecode &&
./obj_dir/simDecode > sim.log 2>&1 ;
cat sim.log ;
grep -q "^Test passed$" sim.log && exit 0 || exit 1
